//--- wb_mem_defines.svh
`ifndef WB_MEM_DEFINES_SVH
`define WB_MEM_DEFINES_SVH

// Word addresses throughout, so one step of the address is one 32-bit word

// Block RAM window
`define WB_BRAM_BASE 32'h0000_0000
`define WB_BRAM_WORDS 1024

// Mailbox window, four registers with the doorbell at offset zero
`define WB_MBOX_BASE 32'h0000_1000
`define WB_MBOX_WORDS 4

// What a read of an address outside both windows returns
`define WB_UNMAPPED_DAT 32'h0000_0000

`endif

//--- wb_mem_pkg.sv
package wb_mem_pkg;

	// Word address as the master presents it
	typedef logic [31:0] wb_adr_t;

	// Read and write data word
	typedef logic [31:0] wb_dat_t;

	// Byte select, bit n enables byte lane n (bits 8n+7 down to 8n)
	typedef logic [3:0] wb_sel_t;

	// Decoder result. SLV_NONE keeps the all-ones pattern for no slave
	typedef enum logic [1:0] {
		SLV_BRAM = 2'b00,
		SLV_MBOX = 2'b01,
		SLV_NONE = 2'b11
	} wb_slave_e;

endpackage

//--- wb_mem_interconnect.sv
`timescale 1ns/10ps
`include "wb_mem_defines.svh"

module wb_mem_interconnect (
	input  logic                clk,
	input  logic                rst,

	input  logic                i_m_we,
	input  logic                i_m_cyc,
	input  logic                i_m_stb,
	input  wb_mem_pkg::wb_sel_t i_m_sel,
	input  wb_mem_pkg::wb_adr_t i_m_adr,
	input  wb_mem_pkg::wb_dat_t i_m_dat,
	output wb_mem_pkg::wb_dat_t o_m_dat,
	output logic                o_m_ack,
	output logic                o_m_int,

	output logic                o_s0_we,
	output logic                o_s0_cyc,
	output logic                o_s0_stb,
	output wb_mem_pkg::wb_sel_t o_s0_sel,
	output wb_mem_pkg::wb_adr_t o_s0_adr,
	output wb_mem_pkg::wb_dat_t o_s0_dat,
	input  wb_mem_pkg::wb_dat_t i_s0_dat,
	input  logic                i_s0_ack,
	input  logic                i_s0_int,

	output logic                o_s1_we,
	output logic                o_s1_cyc,
	output logic                o_s1_stb,
	output wb_mem_pkg::wb_sel_t o_s1_sel,
	output wb_mem_pkg::wb_adr_t o_s1_adr,
	output wb_mem_pkg::wb_dat_t o_s1_dat,
	input  wb_mem_pkg::wb_dat_t i_s1_dat,
	input  logic                i_s1_ack,
	input  logic                i_s1_int
);
	import wb_mem_pkg::*;

	wb_slave_e slv_sel;
	logic      hit_bram;
	logic      hit_mbox;
	logic      m_req;

	// Window checks against the address map. An address below a base wraps
	// to a large offset and so falls outside that window
	assign hit_bram = (i_m_adr - `WB_BRAM_BASE) < `WB_BRAM_WORDS;
	assign hit_mbox = (i_m_adr - `WB_MBOX_BASE) < `WB_MBOX_WORDS;

	assign m_req = i_m_cyc && i_m_stb;

	always_comb begin
		if (rst) begin
			slv_sel = SLV_NONE;
		end
		else if (hit_bram) begin
			slv_sel = SLV_BRAM;
		end
		else if (hit_mbox) begin
			slv_sel = SLV_MBOX;
		end
		else begin
			slv_sel = SLV_NONE;
		end
	end

	// Return path from whichever slave is addressed
	always_comb begin
		case (slv_sel)
			SLV_BRAM: begin
				o_m_dat = i_s0_dat;
				o_m_ack = i_s0_ack;
				o_m_int = i_s0_int;
			end
			SLV_MBOX: begin
				o_m_dat = i_s1_dat;
				o_m_ack = i_s1_ack;
				o_m_int = i_s1_int;
			end
			default: begin
				o_m_dat = `WB_UNMAPPED_DAT;
				o_m_ack = m_req;        // Nobody home, answer straight away
				o_m_int = 1'b0;
			end
		endcase
	end

	// Only the addressed slave sees the request, the other one sees zeros
	assign o_s0_we  = (slv_sel == SLV_BRAM) ? i_m_we  : 1'b0;
	assign o_s0_cyc = (slv_sel == SLV_BRAM) ? i_m_cyc : 1'b0;
	assign o_s0_stb = (slv_sel == SLV_BRAM) ? i_m_stb : 1'b0;
	assign o_s0_sel = (slv_sel == SLV_BRAM) ? i_m_sel : '0;
	assign o_s0_adr = (slv_sel == SLV_BRAM) ? i_m_adr : '0;
	assign o_s0_dat = (slv_sel == SLV_BRAM) ? i_m_dat : '0;

	assign o_s1_we  = (slv_sel == SLV_MBOX) ? i_m_we  : 1'b0;
	assign o_s1_cyc = (slv_sel == SLV_MBOX) ? i_m_cyc : 1'b0;
	assign o_s1_stb = (slv_sel == SLV_MBOX) ? i_m_stb : 1'b0;
	assign o_s1_sel = (slv_sel == SLV_MBOX) ? i_m_sel : '0;
	assign o_s1_adr = (slv_sel == SLV_MBOX) ? i_m_adr : '0;
	assign o_s1_dat = (slv_sel == SLV_MBOX) ? i_m_dat : '0;

endmodule

//--- wb_bram_slave.sv
`timescale 1ns/10ps
`include "wb_mem_defines.svh"

module wb_bram_slave (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_we,
	input  logic                i_cyc,
	input  logic                i_stb,
	input  wb_mem_pkg::wb_sel_t i_sel,
	input  wb_mem_pkg::wb_adr_t i_adr,
	input  wb_mem_pkg::wb_dat_t i_dat,
	output wb_mem_pkg::wb_dat_t o_dat,
	output logic                o_ack
);
	import wb_mem_pkg::*;

	localparam int ADR_W = $clog2(`WB_BRAM_WORDS);
	localparam int LANES = $bits(wb_sel_t);

	wb_dat_t          mem [`WB_BRAM_WORDS];
	logic [ADR_W-1:0] word_idx;
	logic             req;

	// The window is aligned, so the low bits index the array directly
	assign word_idx = i_adr[ADR_W-1:0];

	// A strobe that is still high while ack is out belongs to the access
	// already answered and must not start a second one
	assign req = i_cyc && i_stb && !o_ack;

	always_ff @(posedge clk) begin
		if (req && i_we) begin
			for (int b = 0; b < LANES; b++) begin
				if (i_sel[b]) begin
					mem[word_idx][8*b +: 8] <= i_dat[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req && !i_we) begin
			o_dat <= mem[word_idx];     // Valid alongside ack
		end
	end

	// One-cycle ack pulse for each accepted request
	always_ff @(posedge clk) begin
		if (rst) begin
			o_ack <= 1'b0;
		end
		else begin
			o_ack <= req;
		end
	end

endmodule

//--- wb_mailbox_slave.sv
`timescale 1ns/10ps
`include "wb_mem_defines.svh"

module wb_mailbox_slave (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_we,
	input  logic                i_cyc,
	input  logic                i_stb,
	input  wb_mem_pkg::wb_sel_t i_sel,
	input  wb_mem_pkg::wb_adr_t i_adr,
	input  wb_mem_pkg::wb_dat_t i_dat,
	output wb_mem_pkg::wb_dat_t o_dat,
	output logic                o_ack,
	output logic                o_int
);
	import wb_mem_pkg::*;

	localparam int IDX_W = $clog2(`WB_MBOX_WORDS);
	localparam int LANES = $bits(wb_sel_t);
	localparam logic [IDX_W-1:0] DOORBELL = '0;

	wb_dat_t          regs [`WB_MBOX_WORDS];
	logic [IDX_W-1:0] word_idx;
	logic             req;
	logic             db_wr_q;
	logic             db_rd_q;

	assign word_idx = i_adr[IDX_W-1:0];
	assign req = i_cyc && i_stb && !o_ack;

	// Register file plus a note of which doorbell access is being acked
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `WB_MBOX_WORDS; w++) begin
				regs[w] <= '0;
			end
			db_wr_q <= 1'b0;
			db_rd_q <= 1'b0;
		end
		else begin
			db_wr_q <= req && i_we && (word_idx == DOORBELL);
			db_rd_q <= req && !i_we && (word_idx == DOORBELL);
			if (req && i_we) begin
				for (int b = 0; b < LANES; b++) begin
					if (i_sel[b]) begin
						regs[word_idx][8*b +: 8] <= i_dat[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req && !i_we) begin
			o_dat <= regs[word_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_ack <= 1'b0;
		end
		else begin
			o_ack <= req;
		end
	end

	// The flag changes on the ack edge, so the doorbell access itself still
	// reports the old level
	always_ff @(posedge clk) begin
		if (rst) begin
			o_int <= 1'b0;
		end
		else if (db_wr_q) begin
			o_int <= 1'b1;
		end
		else if (db_rd_q) begin
			o_int <= 1'b0;              // Reading the doorbell acknowledges it
		end
	end

endmodule

//--- wb_mem_top.sv
`timescale 1ns/10ps

module wb_mem_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_m_we,
	input  logic                i_m_cyc,
	input  logic                i_m_stb,
	input  wb_mem_pkg::wb_sel_t i_m_sel,
	input  wb_mem_pkg::wb_adr_t i_m_adr,
	input  wb_mem_pkg::wb_dat_t i_m_dat,
	output wb_mem_pkg::wb_dat_t o_m_dat,
	output logic                o_m_ack,
	output logic                o_m_int
);
	import wb_mem_pkg::*;

	// Slave 0 is the block RAM
	logic    s0_we;
	logic    s0_cyc;
	logic    s0_stb;
	wb_sel_t s0_sel;
	wb_adr_t s0_adr;
	wb_dat_t s0_wdat;
	wb_dat_t s0_rdat;
	logic    s0_ack;

	// Slave 1 is the mailbox
	logic    s1_we;
	logic    s1_cyc;
	logic    s1_stb;
	wb_sel_t s1_sel;
	wb_adr_t s1_adr;
	wb_dat_t s1_wdat;
	wb_dat_t s1_rdat;
	logic    s1_ack;
	logic    s1_int;

	wb_mem_interconnect u_interconnect (
		.clk      (clk),
		.rst      (rst),
		.i_m_we   (i_m_we),
		.i_m_cyc  (i_m_cyc),
		.i_m_stb  (i_m_stb),
		.i_m_sel  (i_m_sel),
		.i_m_adr  (i_m_adr),
		.i_m_dat  (i_m_dat),
		.o_m_dat  (o_m_dat),
		.o_m_ack  (o_m_ack),
		.o_m_int  (o_m_int),
		.o_s0_we  (s0_we),
		.o_s0_cyc (s0_cyc),
		.o_s0_stb (s0_stb),
		.o_s0_sel (s0_sel),
		.o_s0_adr (s0_adr),
		.o_s0_dat (s0_wdat),
		.i_s0_dat (s0_rdat),
		.i_s0_ack (s0_ack),
		.i_s0_int (1'b0),           // The RAM never interrupts
		.o_s1_we  (s1_we),
		.o_s1_cyc (s1_cyc),
		.o_s1_stb (s1_stb),
		.o_s1_sel (s1_sel),
		.o_s1_adr (s1_adr),
		.o_s1_dat (s1_wdat),
		.i_s1_dat (s1_rdat),
		.i_s1_ack (s1_ack),
		.i_s1_int (s1_int)
	);

	wb_bram_slave u_bram (
		.clk   (clk),
		.rst   (rst),
		.i_we  (s0_we),
		.i_cyc (s0_cyc),
		.i_stb (s0_stb),
		.i_sel (s0_sel),
		.i_adr (s0_adr),
		.i_dat (s0_wdat),
		.o_dat (s0_rdat),
		.o_ack (s0_ack)
	);

	wb_mailbox_slave u_mbox (
		.clk   (clk),
		.rst   (rst),
		.i_we  (s1_we),
		.i_cyc (s1_cyc),
		.i_stb (s1_stb),
		.i_sel (s1_sel),
		.i_adr (s1_adr),
		.i_dat (s1_wdat),
		.o_dat (s1_rdat),
		.o_ack (s1_ack),
		.o_int (s1_int)
	);

endmodule

//--- tb_wb_mem_top.sv
`timescale 1ns/10ps
`include "wb_mem_defines.svh"

module tb_wb_mem_top;
	import wb_mem_pkg::*;

	localparam int      RST_CYCLES = 8;
	localparam int      ACK_WAIT   = 4;
	localparam wb_adr_t RAM_FIRST  = `WB_BRAM_BASE;
	localparam wb_adr_t RAM_LAST   = `WB_BRAM_BASE + `WB_BRAM_WORDS - 1;
	localparam wb_adr_t MBOX       = `WB_MBOX_BASE;
	localparam wb_adr_t UNMAP_LO   = `WB_BRAM_BASE + `WB_BRAM_WORDS;  // First word past the RAM
	localparam wb_adr_t UNMAP_HI   = `WB_MBOX_BASE + `WB_MBOX_WORDS;

	// One bus access with what the master expects to see at its ack
	typedef struct packed {
		logic    we;
		wb_adr_t adr;
		wb_sel_t sel;
		wb_dat_t dat;
		wb_dat_t exp_dat;
		logic    exp_int;
	} step_t;

	logic    clk;
	logic    rst;
	logic    i_m_we;
	logic    i_m_cyc;
	logic    i_m_stb;
	wb_sel_t i_m_sel;
	wb_adr_t i_m_adr;
	wb_dat_t i_m_dat;
	wb_dat_t o_m_dat;
	logic    o_m_ack;
	logic    o_m_int;

	step_t   steps [$];
	int      seed;
	int      cycle_cnt   = 0;
	int      cycle_limit = 0;

	wb_mem_top u_dut (
		.clk     (clk),
		.rst     (rst),
		.i_m_we  (i_m_we),
		.i_m_cyc (i_m_cyc),
		.i_m_stb (i_m_stb),
		.i_m_sel (i_m_sel),
		.i_m_adr (i_m_adr),
		.i_m_dat (i_m_dat),
		.o_m_dat (o_m_dat),
		.o_m_ack (o_m_ack),
		.o_m_int (o_m_int)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Simulation ran past its limit of %0d cycles", cycle_limit);
			abort_run();
		end
	end

	task automatic check_dat(input string name, input wb_dat_t exp_val, input wb_dat_t act_val);
		if (act_val !== exp_val) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
			abort_run();
		end
	endtask

	task automatic check_int(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp_val, act_val);
			abort_run();
		end
	endtask

	// Old word with the selected byte lanes taken from the new word
	function automatic wb_dat_t merge_bytes(wb_dat_t old_word, wb_dat_t new_word, wb_sel_t sel);
		wb_dat_t result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	task automatic write_step(input wb_adr_t adr, input wb_sel_t sel, input wb_dat_t dat,
			input logic exp_int);
		step_t s;
		s = '{we: 1'b1, adr: adr, sel: sel, dat: dat, exp_dat: '0, exp_int: exp_int};
		steps.push_back(s);
	endtask

	task automatic read_step(input wb_adr_t adr, input wb_dat_t exp_dat, input logic exp_int);
		step_t s;
		s = '{we: 1'b0, adr: adr, sel: 4'hf, dat: '0, exp_dat: exp_dat, exp_int: exp_int};
		steps.push_back(s);
	endtask

	task automatic build_steps();
		wb_dat_t rnd [13];
		wb_dat_t db_val;
		for (int i = 0; i < 13; i++) begin
			rnd[i] = $random(seed);
		end
		db_val = rnd[12];

		// RAM full words, first and last word included
		write_step(RAM_FIRST, 4'hf, rnd[0], 1'b0);
		write_step(RAM_FIRST + 1, 4'hf, rnd[1], 1'b0);
		write_step(RAM_FIRST + 17, 4'hf, rnd[2], 1'b0);
		write_step(RAM_LAST, 4'hf, rnd[3], 1'b0);
		read_step(RAM_FIRST, rnd[0], 1'b0);
		read_step(RAM_FIRST + 1, rnd[1], 1'b0);
		read_step(RAM_FIRST + 17, rnd[2], 1'b0);
		read_step(RAM_LAST, rnd[3], 1'b0);

		write_step(RAM_FIRST + 5, 4'hf, rnd[4], 1'b0);
		write_step(RAM_FIRST + 5, 4'b0101, rnd[5], 1'b0);
		read_step(RAM_FIRST + 5, merge_bytes(rnd[4], rnd[5], 4'b0101), 1'b0);
		write_step(RAM_LAST, 4'b1000, rnd[6], 1'b0);
		read_step(RAM_LAST, merge_bytes(rnd[3], rnd[6], 4'b1000), 1'b0);

		// Scratch words share low bits with RAM words 1 to 3
		write_step(MBOX + 1, 4'hf, rnd[7], 1'b0);
		write_step(MBOX + 2, 4'hf, rnd[8], 1'b0);
		write_step(MBOX + 3, 4'hf, rnd[9], 1'b0);
		write_step(MBOX + 2, 4'b0011, rnd[10], 1'b0);
		write_step(RAM_FIRST + 2, 4'hf, rnd[11], 1'b0);
		read_step(MBOX + 1, rnd[7], 1'b0);
		read_step(MBOX + 2, merge_bytes(rnd[8], rnd[10], 4'b0011), 1'b0);
		read_step(MBOX + 3, rnd[9], 1'b0);
		read_step(RAM_FIRST + 1, rnd[1], 1'b0);
		read_step(RAM_FIRST + 2, rnd[11], 1'b0);

		// Doorbell write still reports the old level at its own ack
		write_step(MBOX, 4'hf, db_val, 1'b0);
		read_step(MBOX + 1, rnd[7], 1'b1);
		read_step(RAM_FIRST, rnd[0], 1'b0);
		read_step(MBOX + 3, rnd[9], 1'b1);
		read_step(MBOX, db_val, 1'b1);
		read_step(MBOX + 1, rnd[7], 1'b0);
		read_step(MBOX, db_val, 1'b0);

		read_step(UNMAP_LO, `WB_UNMAPPED_DAT, 1'b0);
		write_step(UNMAP_LO, 4'hf, rnd[9], 1'b0);
		write_step(UNMAP_LO + 5, 4'hf, rnd[10], 1'b0);
		write_step(UNMAP_HI, 4'hf, rnd[0], 1'b0);
		read_step(32'h8000_0000, `WB_UNMAPPED_DAT, 1'b0);
		read_step(RAM_FIRST, rnd[0], 1'b0);
		read_step(RAM_FIRST + 5, merge_bytes(rnd[4], rnd[5], 4'b0101), 1'b0);
		read_step(MBOX, db_val, 1'b0);
	endtask

	// Classic single cycle, data and interrupt are taken with the ack
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_sel_t sel,
			input wb_dat_t dat, output wb_dat_t rd_dat, output logic rd_int);
		int waited;
		@(negedge clk);
		i_m_cyc = 1'b1;
		i_m_stb = 1'b1;
		i_m_we  = we;
		i_m_sel = sel;
		i_m_adr = adr;
		i_m_dat = dat;
		waited = 0;
		#1;                             // Unmapped ack is combinational, let it settle
		while (!o_m_ack) begin
			if (waited == ACK_WAIT) begin
				$display("No ack within %0d cycles for address %h at %0t ns", ACK_WAIT, adr, $time);
				abort_run();
			end
			else begin
				@(negedge clk);
				waited++;
			end
		end
		rd_dat = o_m_dat;
		rd_int = o_m_int;
		@(posedge clk);
		@(negedge clk);
		i_m_cyc = 1'b0;
		i_m_stb = 1'b0;
		i_m_we  = 1'b0;
	endtask

	initial begin
		wb_dat_t rd_dat;
		logic    rd_int;
		rst     = 1'b1;
		i_m_we  = 1'b0;
		i_m_cyc = 1'b0;
		i_m_stb = 1'b0;
		i_m_sel = '0;
		i_m_adr = '0;
		i_m_dat = '0;
		seed    = 32'hd4f3;
		build_steps();
		cycle_limit = 10 * steps.size() + RST_CYCLES;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;

		foreach (steps[i]) begin
			bus_cycle(steps[i].we, steps[i].adr, steps[i].sel, steps[i].dat, rd_dat, rd_int);
			if (!steps[i].we) begin
				check_dat($sformatf("o_m_dat (step %0d)", i), steps[i].exp_dat, rd_dat);
			end
			check_int($sformatf("o_m_int (step %0d)", i), steps[i].exp_int, rd_int);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

//--- build.f
+incdir+.
wb_mem_pkg.sv
wb_mem_interconnect.sv
wb_bram_slave.sv
wb_mailbox_slave.sv
wb_mem_top.sv
tb_wb_mem_top.sv

//--- Makefile
# Verilator build and run of the Wishbone memory subsystem testbench
# The run target fails whenever the testbench stops on $fatal

TOP  := tb_wb_mem_top
SRCS := $(filter %.sv,$(shell cat build.f))

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f wb_mem_defines.svh $(SRCS)
	verilator --binary --timing --timescale 1ns/10ps \
		-f build.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
